// ==== sources.f ====
+incdir+common
common/pipeline_tail_pkg.sv
logic/bit_sync.sv
logic/pulse_sync.sv
drawing/drawing_manager.sv
framebuffer/frame_buffer.sv
display/vga_display.sv
logic/pipeline_tail.sv
verification/pipeline_tail_properties.sv
verification/pipeline_tail_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipeline tail testbench

VERILATOR ?= verilator
TOP       ?= pipeline_tail_tb
RTL_TOP   ?= pipeline_tail
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) && ! grep -q "%Error" $(LOG) \
		&& echo "simulation passed" \
		|| (echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/pipeline_tail_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_tail_config.svh"

module pipeline_tail_tb;

    localparam int NPIX    = `PT_BUF_WIDTH * `PT_BUF_HEIGHT;
    localparam int H_TOTAL = `PT_H_ACTIVE + `PT_H_FRONT + `PT_H_SYNC + `PT_H_BACK;
    localparam int V_TOTAL = `PT_V_ACTIVE + `PT_V_FRONT + `PT_V_SYNC + `PT_V_BACK;
    localparam int V_SYNC_START = `PT_V_ACTIVE + `PT_V_FRONT;
    localparam int SYS_LIMIT  = 5000;
    localparam int DISP_LIMIT = 4000;

    logic                               clk_system;
    logic                               clk_display;
    logic                               rstn_system;
    logic                               rstn_display;
    logic                               pixel_valid;
    pipeline_tail_pkg::pixel_data_t     pixel_data;
    pipeline_tail_pkg::pixel_metadata_t pixel_meta;
    logic                               pixel_ready;
    pipeline_tail_pkg::vga_out_t        vga;
    logic                               debug_depth_buffer;
    logic                               debug_active_frame_buffer;

    // Reference image and the last captured frame
    pipeline_tail_pkg::color_t model_color [NPIX];
    logic [7:0]                model_depth [NPIX];
    pipeline_tail_pkg::color_t saved_color [NPIX];
    pipeline_tail_pkg::color_t shown [NPIX];

    logic [6:0]                q_addr [$];
    pipeline_tail_pkg::color_t q_color [$];
    logic [7:0]                q_depth [$];

    logic grey_mode;
    int   hs_lows;
    int   vs_lows;
    int   stray_colors;
    int   test_errors;
    int   errors;
    int   tests_run;
    int   tests_failed;
    int   seed;

    pipeline_tail dut (
        .clk_system                (clk_system),
        .rstn_system               (rstn_system),
        .clk_display               (clk_display),
        .rstn_display              (rstn_display),
        .pixel_valid               (pixel_valid),
        .pixel_data                (pixel_data),
        .pixel_meta                (pixel_meta),
        .pixel_ready               (pixel_ready),
        .vga                       (vga),
        .debug_depth_buffer        (debug_depth_buffer),
        .debug_active_frame_buffer (debug_active_frame_buffer)
    );

    initial begin
        clk_display = 1'b0;
        forever #2 clk_display = ~clk_display;
    end

    initial begin
        clk_system = 1'b0;
        forever #3 clk_system = ~clk_system;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task automatic reset_model();
        for (int i = 0; i < NPIX; i++) begin
            model_color[i] = `PT_CLEAR_COLOR;
            model_depth[i] = 8'hFF;
        end
    endtask

    // Strictly nearer pixels replace the stored one
    task automatic queue_pixel(input logic [6:0] addr, input logic [11:0] color,
                               input logic [7:0] depth);
        q_addr.push_back(addr);
        q_color.push_back(color);
        q_depth.push_back(depth);
        if (depth < model_depth[addr]) begin
            model_depth[addr] = depth;
            model_color[addr] = grey_mode ? {depth[7:4], depth[7:4], depth[7:4]} : color;
        end
    endtask

    // Stride 37 is coprime to the buffer size so addresses never repeat
    task automatic queue_random_frame(input int count, input int offset);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            if (r[19:12] == 8'hFF) begin
                r[19:12] = 8'hFE;
            end
            queue_pixel(7'((i * 37 + offset) % NPIX), r[11:0], r[19:12]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and capture
    //////////////////////////////////////////////////////////////////////

    task automatic send_queued(input logic mark_last);
        int n;
        @(posedge clk_system);
        for (int i = 0; i < q_addr.size(); i++) begin
            pixel_valid      <= 1'b1;
            pixel_data.x     <= q_addr[i][3:0];
            pixel_data.y     <= q_addr[i][6:4];
            pixel_data.color <= q_color[i];
            pixel_meta.depth <= q_depth[i];
            pixel_meta.last  <= mark_last && (i == q_addr.size() - 1);
            n = 0;
            do begin
                @(posedge clk_system);
                n++;
            end while (!pixel_ready && n < SYS_LIMIT);
            if (n >= SYS_LIMIT) begin
                $display("timeout: pixel %0d was never accepted", i);
                test_errors++;
            end
        end
        pixel_valid <= 1'b0;
        q_addr.delete();
        q_color.delete();
        q_depth.delete();
    endtask

    task automatic wait_vsync_start();
        logic prev;
        int   n;
        @(negedge clk_display);
        prev = (vga.vsync == `PT_SYNC_POL);
        n = 0;
        while (n < DISP_LIMIT) begin
            @(negedge clk_display);
            if (!prev && vga.vsync == `PT_SYNC_POL) begin
                break;
            end
            prev = (vga.vsync == `PT_SYNC_POL);
            n++;
        end
        if (n >= DISP_LIMIT) begin
            $display("timeout: no vertical sync seen");
            test_errors++;
        end
    endtask

    // Sample 0 is the first vsync cycle, which shows line V_SYNC_START
    task automatic read_frame();
        int v;
        int h;
        hs_lows      = 0;
        vs_lows      = 0;
        stray_colors = 0;
        for (int k = 0; k < H_TOTAL * V_TOTAL; k++) begin
            if (k > 0) begin
                @(negedge clk_display);
            end
            v = (V_SYNC_START + k / H_TOTAL) % V_TOTAL;
            h = k % H_TOTAL;
            if (vga.hsync == `PT_SYNC_POL) hs_lows++;
            if (vga.vsync == `PT_SYNC_POL) vs_lows++;
            if (v < `PT_V_ACTIVE && h < `PT_H_ACTIVE) begin
                shown[v * `PT_BUF_WIDTH + h] = vga.color;
            end else if (vga.color !== 12'h000) begin
                stray_colors++;
            end
        end
    endtask

    task automatic capture_frame();
        wait_vsync_start();
        read_frame();
    endtask

    task automatic wait_swap(input logic old_select);
        int n;
        n = 0;
        while (dut.buffer_select == old_select && n < DISP_LIMIT) begin
            @(posedge clk_display);
            n++;
        end
        if (n >= DISP_LIMIT) begin
            $display("timeout: buffers never swapped");
            test_errors++;
        end
    endtask

    task automatic compare_frame(input string name,
                                 input pipeline_tail_pkg::color_t expected [NPIX]);
        int bad;
        bad = 0;
        for (int i = 0; i < NPIX; i++) begin
            if (shown[i] !== expected[i]) begin
                if (bad < 8) begin
                    $display("ERR %s pixel %0d expected %h actual %h",
                             name, i, expected[i], shown[i]);
                end
                bad++;
            end
        end
        if (stray_colors != 0) begin
            $display("ERR %s stray colors expected 0 actual %0d", name, stray_colors);
            bad++;
        end
        test_errors += bad;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end else begin
            $display("test %s: passed", name);
        end
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int n;
        if (vga.hsync !== 1'b1 || vga.vsync !== 1'b1) begin
            $display("ERR reset sync expected 11 actual %b%b", vga.hsync, vga.vsync);
            test_errors++;
        end
        if (vga.color !== 12'h000 || pixel_ready !== 1'b0) begin
            $display("ERR reset color/ready expected 000/0 actual %h/%b",
                     vga.color, pixel_ready);
            test_errors++;
        end
        rstn_system  <= 1'b1;
        rstn_display <= 1'b1;
        n = 0;
        do begin
            @(posedge clk_system);
            n++;
        end while (!pixel_ready && n < SYS_LIMIT);
        if (n < NPIX || n > NPIX + 3) begin
            $display("ERR reset clear cycles expected %0d actual %0d", NPIX, n);
            test_errors++;
        end
        finish_test("reset");
    endtask

    task automatic test_sync();
        capture_frame();
        if (hs_lows != `PT_H_SYNC * V_TOTAL) begin
            $display("ERR sync hsync lows expected %0d actual %0d",
                     `PT_H_SYNC * V_TOTAL, hs_lows);
            test_errors++;
        end
        if (vs_lows != `PT_V_SYNC * H_TOTAL) begin
            $display("ERR sync vsync lows expected %0d actual %0d",
                     `PT_V_SYNC * H_TOTAL, vs_lows);
            test_errors++;
        end
        if (stray_colors != 0) begin
            $display("ERR sync stray colors expected 0 actual %0d", stray_colors);
            test_errors++;
        end
        finish_test("sync");
    endtask

    task automatic test_draw_swap();
        logic old;
        old = dut.buffer_select;
        reset_model();
        queue_random_frame(24, 3);
        send_queued(1'b1);
        wait_swap(old);
        capture_frame();
        compare_frame("draw_swap", model_color);
        finish_test("draw_swap");
    endtask

    task automatic test_depth();
        logic old;
        old = dut.buffer_select;
        reset_model();
        queue_pixel(7'd5, 12'hF00, 8'd80);
        queue_pixel(7'd5, 12'h0F0, 8'd40);
        queue_pixel(7'd5, 12'h00F, 8'd40);
        queue_pixel(7'd5, 12'hFFF, 8'd90);
        queue_pixel(7'd6, 12'h333, 8'd200);
        queue_pixel(7'd6, 12'h555, 8'd10);
        queue_pixel(7'd6, 12'h777, 8'd10);
        for (int i = 0; i < 12; i++) begin
            queue_pixel(7'(32 + $unsigned($random(seed)) % 4), 12'(i * 291 + 17),
                        8'($unsigned($random(seed)) % 250));
        end
        send_queued(1'b1);
        wait_swap(old);
        capture_frame();
        compare_frame("depth", model_color);
        finish_test("depth");
    endtask

    task automatic test_double_buffer();
        logic old;
        int   n;
        old = dut.buffer_select;
        reset_model();
        queue_random_frame(20, 11);
        send_queued(1'b1);
        // Upstream must stall until the display takes the frame
        n = 0;
        while (dut.buffer_select == old && n < SYS_LIMIT) begin
            @(posedge clk_system);
            if (pixel_ready) begin
                $display("ERR double_buffer pixel_ready expected 0 actual %b", pixel_ready);
                test_errors++;
            end
            n++;
        end
        if (n >= SYS_LIMIT) begin
            $display("timeout: frame 1 was never swapped to the display");
            test_errors++;
        end
        capture_frame();
        compare_frame("double_buffer_f1", model_color);
        saved_color = model_color;
        old = dut.buffer_select;
        reset_model();
        queue_random_frame(20, 50);
        wait_vsync_start();
        fork
            read_frame();
            send_queued(1'b1);
        join
        compare_frame("double_buffer_hold", saved_color);
        wait_swap(old);
        capture_frame();
        compare_frame("double_buffer_f2", model_color);
        finish_test("double_buffer");
    endtask

    task automatic test_debug();
        logic old;
        old = dut.buffer_select;
        grey_mode = 1'b1;
        @(posedge clk_system);
        debug_depth_buffer <= 1'b1;
        reset_model();
        queue_random_frame(16, 7);
        send_queued(1'b0);
        repeat (4) @(posedge clk_system);
        @(posedge clk_display);
        debug_active_frame_buffer <= 1'b1;
        capture_frame();
        compare_frame("debug_back", model_color);
        @(posedge clk_display);
        debug_active_frame_buffer <= 1'b0;
        queue_pixel(7'd127, 12'hABC, 8'd1);
        send_queued(1'b1);
        wait_swap(old);
        capture_frame();
        compare_frame("debug_grey", model_color);
        @(posedge clk_system);
        debug_depth_buffer <= 1'b0;
        grey_mode = 1'b0;
        finish_test("debug");
    endtask

    initial begin
        seed                      = 38499;
        grey_mode                 = 1'b0;
        test_errors               = 0;
        errors                    = 0;
        tests_run                 = 0;
        tests_failed              = 0;
        rstn_system               = 1'b0;
        rstn_display              = 1'b0;
        pixel_valid               = 1'b0;
        pixel_data                = '0;
        pixel_meta                = '0;
        debug_depth_buffer        = 1'b0;
        debug_active_frame_buffer = 1'b0;
        repeat (8) @(posedge clk_system);

        test_reset();
        test_sync();
        test_draw_swap();
        test_depth();
        test_double_buffer();
        test_debug();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/pipeline_tail_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_tail_config.svh"

module pipeline_tail_properties (
    input logic                               clk_system,
    input logic                               rstn_system,
    input logic                               clk_display,
    input logic                               rstn_display,
    input logic                               pixel_valid,
    input logic                               pixel_ready,
    input pipeline_tail_pkg::pixel_data_t     pixel_data,
    input pipeline_tail_pkg::pixel_metadata_t pixel_meta,
    input logic                               draw_ack,
    input logic                               frame_done,
    input pipeline_tail_pkg::vga_out_t        vga
);

    // Sender holds the pixel while the manager stalls
    hold_pixel: assert property (@(posedge clk_system) disable iff (!rstn_system)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_data)
                                        && $stable(pixel_meta))
        else $error("pixel stream changed while stalled");

    ack_one_cycle: assert property (@(posedge clk_system) disable iff (!rstn_system)
        draw_ack |=> !draw_ack)
        else $error("draw_ack longer than one cycle");

    done_until_ack: assert property (@(posedge clk_system) disable iff (!rstn_system)
        frame_done && !draw_ack |=> frame_done)
        else $error("frame_done dropped before draw_ack");

    // Both sync pulses lie in the blanking area
    blank_color: assert property (@(posedge clk_display) disable iff (!rstn_display)
        (vga.hsync == `PT_SYNC_POL) || (vga.vsync == `PT_SYNC_POL) |-> vga.color == '0)
        else $error("color driven during sync");

endmodule

bind pipeline_tail pipeline_tail_properties props (
    .clk_system  (clk_system),
    .rstn_system (rstn_system),
    .clk_display (clk_display),
    .rstn_display(rstn_display),
    .pixel_valid (pixel_valid),
    .pixel_ready (pixel_ready),
    .pixel_data  (pixel_data),
    .pixel_meta  (pixel_meta),
    .draw_ack    (draw_ack),
    .frame_done  (frame_done),
    .vga         (vga)
);

`default_nettype wire

// ==== logic/pipeline_tail.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_tail_config.svh"

module pipeline_tail (
    input  logic                               clk_system,
    input  logic                               rstn_system,
    input  logic                               clk_display,
    input  logic                               rstn_display,
    input  logic                               pixel_valid,
    input  pipeline_tail_pkg::pixel_data_t     pixel_data,
    input  pipeline_tail_pkg::pixel_metadata_t pixel_meta,
    output logic                               pixel_ready,
    output pipeline_tail_pkg::vga_out_t        vga,
    input  logic                               debug_depth_buffer,
    input  logic                               debug_active_frame_buffer
);

    pipeline_tail_pkg::fb_write_t dm_write;
    pipeline_tail_pkg::fb_write_t fb_write_a;
    pipeline_tail_pkg::fb_write_t fb_write_b;
    logic                         frame_done;
    logic                         draw_ack;

    logic                         buffer_select;
    logic                         buffer_select_sys;
    logic                         frame_done_disp;
    logic                         vsync_d;
    logic                         vsync_start;
    logic                         swap_req;

    logic [`PT_ADDR_WIDTH-1:0]    read_addr;
    pipeline_tail_pkg::color_t    fb_a_read_data;
    pipeline_tail_pkg::color_t    fb_b_read_data;
    pipeline_tail_pkg::color_t    disp_read_data;

    //////////////////////////////////////////////////////////////////////
    // Buffer swap
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vsync_d       <= ~`PT_SYNC_POL;
            buffer_select <= 1'b0;
        end else begin
            vsync_d <= vga.vsync;
            if (swap_req) begin
                buffer_select <= ~buffer_select;
            end
        end
    end

    // First cycle of the vertical sync pulse
    assign vsync_start = (vga.vsync == `PT_SYNC_POL) && (vsync_d != `PT_SYNC_POL);
    assign swap_req    = vsync_start && frame_done_disp;

    bit_sync frame_done_sync (
        .clk       (clk_display),
        .rstn      (rstn_display),
        .level_in  (frame_done),
        .level_out (frame_done_disp)
    );

    bit_sync buffer_select_sync (
        .clk       (clk_system),
        .rstn      (rstn_system),
        .level_in  (buffer_select),
        .level_out (buffer_select_sys)
    );

    pulse_sync draw_ack_sync (
        .clk_src   (clk_display),
        .rstn_src  (rstn_display),
        .clk_dst   (clk_system),
        .rstn_dst  (rstn_system),
        .pulse_in  (swap_req),
        .pulse_out (draw_ack)
    );

    //////////////////////////////////////////////////////////////////////
    // Steering
    //////////////////////////////////////////////////////////////////////

    // Drawing goes to the back buffer, A while select is low
    always_comb begin
        fb_write_a    = dm_write;
        fb_write_b    = dm_write;
        fb_write_a.en = dm_write.en && !buffer_select_sys;
        fb_write_b.en = dm_write.en && buffer_select_sys;
    end

    // Front is B while select is low, debug flips to the back buffer
    assign disp_read_data = (buffer_select ^ debug_active_frame_buffer)
                          ? fb_a_read_data : fb_b_read_data;

    drawing_manager drawing_manager (
        .clk_system         (clk_system),
        .rstn_system        (rstn_system),
        .draw_ack           (draw_ack),
        .pixel_valid        (pixel_valid),
        .pixel_data         (pixel_data),
        .pixel_meta         (pixel_meta),
        .pixel_ready        (pixel_ready),
        .debug_depth_buffer (debug_depth_buffer),
        .fb_write           (dm_write),
        .frame_done         (frame_done)
    );

    frame_buffer frame_buffer_a (
        .clk_write (clk_system),
        .fb_write  (fb_write_a),
        .clk_read  (clk_display),
        .read_addr (read_addr),
        .read_data (fb_a_read_data)
    );

    frame_buffer frame_buffer_b (
        .clk_write (clk_system),
        .fb_write  (fb_write_b),
        .clk_read  (clk_display),
        .read_addr (read_addr),
        .read_data (fb_b_read_data)
    );

    vga_display vga_display (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .read_addr    (read_addr),
        .read_data    (disp_read_data),
        .vga          (vga)
    );

endmodule

`default_nettype wire

// ==== display/vga_display.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_tail_config.svh"

module vga_display (
    input  logic                         clk_display,
    input  logic                         rstn_display,
    output logic [`PT_ADDR_WIDTH-1:0]    read_addr,
    input  pipeline_tail_pkg::color_t    read_data,
    output pipeline_tail_pkg::vga_out_t  vga
);

    localparam int ADDR_W  = `PT_ADDR_WIDTH;
    localparam int H_TOTAL = `PT_H_ACTIVE + `PT_H_FRONT + `PT_H_SYNC + `PT_H_BACK;
    localparam int V_TOTAL = `PT_V_ACTIVE + `PT_V_FRONT + `PT_V_SYNC + `PT_V_BACK;
    localparam int H_W     = $clog2(H_TOTAL);
    localparam int V_W     = $clog2(V_TOTAL);
    localparam int H_SYNC_START = `PT_H_ACTIVE + `PT_H_FRONT;
    localparam int V_SYNC_START = `PT_V_ACTIVE + `PT_V_FRONT;

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           active;
    logic           h_in_sync;
    logic           v_in_sync;

    logic           active_q;
    logic           hsync_q;
    logic           vsync_q;

    //////////////////////////////////////////////////////////////////////
    // Scan counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == V_W'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign active    = (h_cnt < `PT_H_ACTIVE) && (v_cnt < `PT_V_ACTIVE);
    assign h_in_sync = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_START + `PT_H_SYNC);
    assign v_in_sync = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_START + `PT_V_SYNC);

    // Address goes out now, the memory answers next cycle
    assign read_addr = active ? ADDR_W'(v_cnt * `PT_BUF_WIDTH + h_cnt) : '0;

    //////////////////////////////////////////////////////////////////////
    // Align flags with read data
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            active_q <= 1'b0;
            hsync_q  <= ~`PT_SYNC_POL;
            vsync_q  <= ~`PT_SYNC_POL;
        end else begin
            active_q <= active;
            hsync_q  <= h_in_sync ? `PT_SYNC_POL : ~`PT_SYNC_POL;
            vsync_q  <= v_in_sync ? `PT_SYNC_POL : ~`PT_SYNC_POL;
        end
    end

    always_comb begin
        vga.hsync = hsync_q;
        vga.vsync = vsync_q;
        vga.color = active_q ? read_data : '0;
    end

endmodule

`default_nettype wire

// ==== framebuffer/frame_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_tail_config.svh"

module frame_buffer (
    input  logic                          clk_write,
    input  pipeline_tail_pkg::fb_write_t  fb_write,
    input  logic                          clk_read,
    input  logic [`PT_ADDR_WIDTH-1:0]     read_addr,
    output pipeline_tail_pkg::color_t     read_data
);

    localparam int NUM_PIXELS = `PT_BUF_WIDTH * `PT_BUF_HEIGHT;

    pipeline_tail_pkg::color_t mem [NUM_PIXELS];

    // Write port in the drawing domain
    always_ff @(posedge clk_write) begin
        if (fb_write.en) begin
            mem[fb_write.addr] <= fb_write.data;
        end
    end

    // Read port in the display domain, one cycle of latency
    always_ff @(posedge clk_read) begin
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

// ==== drawing/drawing_manager.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_tail_config.svh"

module drawing_manager (
    input  logic                               clk_system,
    input  logic                               rstn_system,
    input  logic                               draw_ack,
    input  logic                               pixel_valid,
    input  pipeline_tail_pkg::pixel_data_t     pixel_data,
    input  pipeline_tail_pkg::pixel_metadata_t pixel_meta,
    output logic                               pixel_ready,
    input  logic                               debug_depth_buffer,
    output pipeline_tail_pkg::fb_write_t       fb_write,
    output logic                               frame_done
);

    localparam int ADDR_W     = `PT_ADDR_WIDTH;
    localparam int DEPTH_W    = `PT_DEPTH_WIDTH;
    localparam int NUM_PIXELS = `PT_BUF_WIDTH * `PT_BUF_HEIGHT;

    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_DRAW,
        ST_DONE
    } state_t;

    state_t                    state;
    logic [ADDR_W-1:0]         clear_cnt;
    logic                      drain;
    logic [DEPTH_W-1:0]        depth_mem [NUM_PIXELS];

    logic                      accept;
    logic                      s1_valid;
    logic [ADDR_W-1:0]         s1_addr;
    pipeline_tail_pkg::color_t s1_color;
    logic [DEPTH_W-1:0]        s1_depth;
    logic                      s1_last;

    logic                      s2_valid;
    logic [ADDR_W-1:0]         s2_addr;
    pipeline_tail_pkg::color_t s2_color;
    logic [DEPTH_W-1:0]        s2_depth;
    logic [DEPTH_W-1:0]        s2_stored;
    logic                      s2_last;
    logic                      s2_write;
    pipeline_tail_pkg::color_t grey;

    assign pixel_ready = (state == ST_DRAW) && !drain;
    assign accept      = pixel_valid && pixel_ready;
    assign frame_done  = (state == ST_DONE);

    // Strictly nearer wins, so equal depth keeps the earlier pixel
    assign s2_write = s2_valid && (s2_depth < s2_stored);

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            state     <= ST_CLEAR;
            clear_cnt <= '0;
            drain     <= 1'b0;
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
            case (state)
                ST_CLEAR: begin
                    clear_cnt <= clear_cnt + 1'b1;
                    if (clear_cnt == ADDR_W'(NUM_PIXELS - 1)) begin
                        state <= ST_DRAW;
                        drain <= 1'b0;
                    end
                end
                ST_DRAW: begin
                    if (accept && pixel_meta.last) begin
                        drain <= 1'b1;
                    end
                    // Last pixel is written this cycle so the pipe is empty after it
                    if (s2_valid && s2_last) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    if (draw_ack) begin
                        state     <= ST_CLEAR;
                        clear_cnt <= '0;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Depth pipeline
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_system) begin
        if (accept) begin
            s1_addr  <= ADDR_W'(pixel_data.y * `PT_BUF_WIDTH + pixel_data.x);
            s1_color <= pixel_data.color;
            s1_depth <= pixel_meta.depth;
            s1_last  <= pixel_meta.last;
        end
        s2_addr  <= s1_addr;
        s2_color <= s1_color;
        s2_depth <= s1_depth;
        s2_last  <= s1_last;
        // Forward the depth being written now when the next pixel hits the same spot
        if (s2_write && (s2_addr == s1_addr)) begin
            s2_stored <= s2_depth;
        end else begin
            s2_stored <= depth_mem[s1_addr];
        end
    end

    always_ff @(posedge clk_system) begin
        if (state == ST_CLEAR) begin
            depth_mem[clear_cnt] <= '1;
        end else if (s2_write) begin
            depth_mem[s2_addr] <= s2_depth;
        end
    end

    // Top depth bits on all three channels for the debug view
    always_comb begin
        grey.red   = s2_depth[DEPTH_W-1 -: 4];
        grey.green = s2_depth[DEPTH_W-1 -: 4];
        grey.blue  = s2_depth[DEPTH_W-1 -: 4];
    end

    always_comb begin
        if (state == ST_CLEAR) begin
            fb_write.en   = 1'b1;
            fb_write.addr = clear_cnt;
            fb_write.data = `PT_CLEAR_COLOR;
        end else begin
            fb_write.en   = s2_write;
            fb_write.addr = s2_addr;
            fb_write.data = debug_depth_buffer ? grey : s2_color;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pulse_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module pulse_sync (
    input  logic clk_src,
    input  logic rstn_src,
    input  logic clk_dst,
    input  logic rstn_dst,
    input  logic pulse_in,
    output logic pulse_out
);

    logic       toggle;
    logic [2:0] sync;

    // Each source pulse flips the level that crosses over
    always_ff @(posedge clk_src or negedge rstn_src) begin
        if (!rstn_src) begin
            toggle <= 1'b0;
        end else if (pulse_in) begin
            toggle <= ~toggle;
        end
    end

    // Two sync flops, one history flop, then a registered edge detect
    always_ff @(posedge clk_dst or negedge rstn_dst) begin
        if (!rstn_dst) begin
            sync      <= 3'b000;
            pulse_out <= 1'b0;
        end else begin
            sync      <= {sync[1:0], toggle};
            pulse_out <= sync[2] ^ sync[1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/bit_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module bit_sync (
    input  logic clk,
    input  logic rstn,
    input  logic level_in,
    output logic level_out
);

    logic meta;

    // First stage may go metastable, second stage settles it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            meta      <= 1'b0;
            level_out <= 1'b0;
        end else begin
            meta      <= level_in;
            level_out <= meta;
        end
    end

endmodule

`default_nettype wire

// ==== common/pipeline_tail_pkg.sv ====
`default_nettype none

`include "pipeline_tail_config.svh"

package pipeline_tail_pkg;

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } color_t;

    // Pixel position inside the buffer plus its color
    typedef struct packed {
        logic [$clog2(`PT_BUF_WIDTH)-1:0]  x;
        logic [$clog2(`PT_BUF_HEIGHT)-1:0] y;
        color_t                            color;
    } pixel_data_t;

    // Sideband that rides along with each pixel
    typedef struct packed {
        logic [`PT_DEPTH_WIDTH-1:0] depth;
        logic                       last;
    } pixel_metadata_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        color_t color;
    } vga_out_t;

    // One write port of a frame buffer
    typedef struct packed {
        logic                      en;
        logic [`PT_ADDR_WIDTH-1:0] addr;
        color_t                    data;
    } fb_write_t;

endpackage

`default_nettype wire

// ==== common/pipeline_tail_config.svh ====
`ifndef PIPELINE_TAIL_CONFIG_SVH
`define PIPELINE_TAIL_CONFIG_SVH

// Buffer geometry
`define PT_BUF_WIDTH    16
`define PT_BUF_HEIGHT   8
`define PT_ADDR_WIDTH   7
`define PT_DEPTH_WIDTH  8

// Horizontal timing in pixels
`define PT_H_ACTIVE     16
`define PT_H_FRONT      2
`define PT_H_SYNC       3
`define PT_H_BACK       3

// Vertical timing in lines
`define PT_V_ACTIVE     8
`define PT_V_FRONT      1
`define PT_V_SYNC       2
`define PT_V_BACK       1

// 0 gives active low sync pulses
`define PT_SYNC_POL     1'b0
`define PT_CLEAR_COLOR  12'h124

`endif
